/* compile.f */
src/read_datapath_pkg.sv
src/read_fifo_if.sv
src/read_latency_ctrl.sv
src/read_fifo_group.sv
src/rdata_mapper.sv
src/oct_ctrl.sv
src/read_datapath.sv
test/tb_read_datapath.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the read datapath testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary -f compile.f --top-module tb_read_datapath -o tb_read_datapath

# A failing check ends in $fatal, which gives a nonzero exit status
./obj_dir/tb_read_datapath

/* src/oct_ctrl.sv */
// On-die termination control, releases termination around each read burst
`default_nettype none

module oct_ctrl
	import read_datapath_pkg::*;
(
	input  logic       pll_afi_clk,
	input  logic       reset_n_afi_clk,
	input  afi_phase_t afi_rdata_en_full_i,
	output afi_phase_t force_oct_off_o
);

	// History of past read enables, bit j sampled j+1 edges ago
	logic [OCT_OFF_DELAY-1:0] rdata_en_q;
	// Same history with the current sample in bit 0
	logic [OCT_OFF_DELAY:0] rdata_en_window;
	logic any_rdata_en;

	assign any_rdata_en = |afi_rdata_en_full_i;
	assign rdata_en_window = {rdata_en_q, any_rdata_en};

	// Termination is forced off only when no read enable sits anywhere in
	// the window from OCT_ON_DELAY to OCT_OFF_DELAY cycles back
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rdata_en_q <= '0;
			force_oct_off_o <= '0;
		end
		else
		begin
			rdata_en_q <= rdata_en_window[OCT_OFF_DELAY-1:0];
			// Both phases carry the same value
			force_oct_off_o <= {AFI_RATE_RATIO{~(|rdata_en_window[OCT_OFF_DELAY:OCT_ON_DELAY])}};
		end
	end

endmodule

`default_nettype wire

/* src/rdata_mapper.sv */
// Read data mapper, builds the AFI and sequencer read buses from the group FIFOs
`default_nettype none

module rdata_mapper
	import read_datapath_pkg::*;
(
	input  logic       pll_afi_clk,
	input  logic       reset_n_afi_clk,
	read_fifo_if.sink  sink0,
	read_fifo_if.sink  sink1,
	input  afi_phase_t read_valid_i,
	output afi_data_t  afi_rdata_o,
	output afi_data_t  phy_mux_read_fifo_q_o,
	output afi_phase_t afi_rdata_valid_o
);

	// Group g sits at index g
	group_data_t [NUM_DQS_GROUPS-1:0] group_word;
	// Time-slot major layout for the controller
	afi_data_t afi_remap;

	assign group_word[0] = sink0.rd_data;
	assign group_word[1] = sink1.rd_data;

	// **************************************************
	// Remapping
	// **************************************************

	// Each time slot takes a full DQ width, and inside it the groups
	// follow in order, so beat t of group g lands at t*8 + g*4
	always_comb
	begin
		afi_remap = '0;
		for (int t = 0; t < NUM_TIMESLOTS; t++)
		begin
			for (int g = 0; g < NUM_DQS_GROUPS; g++)
			begin
				afi_remap[MEM_DQ_WIDTH*t + DQ_GROUP_WIDTH*g +: DQ_GROUP_WIDTH] =
					group_word[g][DQ_GROUP_WIDTH*t +: DQ_GROUP_WIDTH];
			end
		end
	end

	// **************************************************
	// Output registers
	// **************************************************

	// The sequencer bus keeps group major order, which is just the two
	// FIFO words side by side
	always_ff @(posedge pll_afi_clk)
	begin
		afi_rdata_o <= afi_remap;
		phy_mux_read_fifo_q_o <= group_word;
	end

	// Valid bits are registered in step with the data
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			afi_rdata_valid_o <= '0;
		end
		else
		begin
			afi_rdata_valid_o <= read_valid_i;
		end
	end

endmodule

`default_nettype wire

/* src/read_datapath.sv */
// Half-rate DDR read datapath top with latency control, group FIFOs, mapper and termination
`default_nettype none

module read_datapath
	import read_datapath_pkg::*;
(
	input  logic                             pll_afi_clk,
	input  logic                             reset_n_afi_clk,
	// Captured beats, group 0 in the low half
	input  group_data_t [NUM_DQS_GROUPS-1:0] ddio_phy_dq_i,
	input  dqs_mask_t                        ddio_capture_i,
	input  dqs_mask_t                        seq_read_fifo_reset_i,
	input  latency_t                         seq_read_latency_count_i,
	input  afi_phase_t                       afi_rdata_en_i,
	input  afi_phase_t                       afi_rdata_en_full_i,
	output afi_data_t                        afi_rdata_o,
	output afi_phase_t                       afi_rdata_valid_o,
	output afi_data_t                        phy_mux_read_fifo_q_o,
	output afi_phase_t                       force_oct_off_o
);

	// Per-phase valid from the latency control to the mapper
	afi_phase_t read_valid;

	// **************************************************
	// Group interfaces
	// **************************************************

	read_fifo_if fifo_if_0 ();
	read_fifo_if fifo_if_1 ();

	// Capture side of each group comes straight from the pins
	assign fifo_if_0.wr_data = ddio_phy_dq_i[0];
	assign fifo_if_0.capture = ddio_capture_i[0];
	assign fifo_if_0.fifo_reset = seq_read_fifo_reset_i[0];

	assign fifo_if_1.wr_data = ddio_phy_dq_i[1];
	assign fifo_if_1.capture = ddio_capture_i[1];
	assign fifo_if_1.fifo_reset = seq_read_fifo_reset_i[1];

	// **************************************************
	// Read latency
	// **************************************************

	read_latency_ctrl u_read_latency_ctrl (
		.pll_afi_clk              (pll_afi_clk),
		.reset_n_afi_clk          (reset_n_afi_clk),
		.afi_rdata_en_i           (afi_rdata_en_i),
		.afi_rdata_en_full_i      (afi_rdata_en_full_i),
		.seq_read_latency_count_i (seq_read_latency_count_i),
		.read_enable0_o           (fifo_if_0.ctrl),
		.read_enable1_o           (fifo_if_1.ctrl),
		.read_valid_o             (read_valid)
	);

	// **************************************************
	// Resynchronization FIFOs
	// **************************************************

	read_fifo_group u_read_fifo_group_0 (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.fifo            (fifo_if_0.fifo)
	);

	read_fifo_group u_read_fifo_group_1 (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.fifo            (fifo_if_1.fifo)
	);

	// **************************************************
	// Output mapping and termination
	// **************************************************

	rdata_mapper u_rdata_mapper (
		.pll_afi_clk           (pll_afi_clk),
		.reset_n_afi_clk       (reset_n_afi_clk),
		.sink0                 (fifo_if_0.sink),
		.sink1                 (fifo_if_1.sink),
		.read_valid_i          (read_valid),
		.afi_rdata_o           (afi_rdata_o),
		.phy_mux_read_fifo_q_o (phy_mux_read_fifo_q_o),
		.afi_rdata_valid_o     (afi_rdata_valid_o)
	);

	// Termination follows the full-rate enables, not the delayed ones
	oct_ctrl u_oct_ctrl (
		.pll_afi_clk         (pll_afi_clk),
		.reset_n_afi_clk     (reset_n_afi_clk),
		.afi_rdata_en_full_i (afi_rdata_en_full_i),
		.force_oct_off_o     (force_oct_off_o)
	);

endmodule

`default_nettype wire

/* src/read_datapath_pkg.sv */
// Read datapath package with the bus widths, FIFO depth, latency and termination constants
`default_nettype none

package read_datapath_pkg;

	// **************************************************
	// Memory and AFI geometry
	// **************************************************

	// Total DQ pins on the memory side
	localparam int MEM_DQ_WIDTH = 8;
	// Each read DQS group strobes its own slice of DQ
	localparam int NUM_DQS_GROUPS = 2;
	localparam int DQ_GROUP_WIDTH = MEM_DQ_WIDTH / NUM_DQS_GROUPS;

	// Half rate means four data beats land in every AFI cycle
	localparam int NUM_TIMESLOTS = 4;
	localparam int AFI_RATE_RATIO = 2;
	localparam int AFI_DATA_WIDTH = MEM_DQ_WIDTH * NUM_TIMESLOTS;

	// One group's word holds all four beats, beat 0 in the low bits
	localparam int GROUP_DATA_WIDTH = DQ_GROUP_WIDTH * NUM_TIMESLOTS;

	// **************************************************
	// Resynchronization FIFO and read latency
	// **************************************************

	localparam int READ_FIFO_DEPTH = 8;
	localparam int READ_FIFO_ADDR_WIDTH = 3;

	// Length of the read enable delay lines, so the largest usable latency count
	localparam int MAX_READ_LATENCY = 15;
	localparam int LATENCY_COUNT_WIDTH = 4;

	// **************************************************
	// On-die termination window
	// **************************************************

	// Memory read latency in memory clocks
	localparam int MEM_T_RL = 11;
	// Termination is released this many AFI cycles after a read enable
	localparam int OCT_ON_DELAY = (MEM_T_RL - 4) / 2;
	// and stays released until this many cycles after it
	localparam int OCT_OFF_DELAY = (MEM_T_RL + 6) / 2;

	// **************************************************
	// Shared types
	// **************************************************

	// Full AFI read bus
	typedef logic [AFI_DATA_WIDTH-1:0] afi_data_t;
	// One DQS group's four beats
	typedef logic [GROUP_DATA_WIDTH-1:0] group_data_t;
	// One bit per AFI phase
	typedef logic [AFI_RATE_RATIO-1:0] afi_phase_t;
	// Sequencer latency count
	typedef logic [LATENCY_COUNT_WIDTH-1:0] latency_t;
	// Resynchronization FIFO pointer
	typedef logic [READ_FIFO_ADDR_WIDTH-1:0] fifo_addr_t;
	// One bit per DQS group
	typedef logic [NUM_DQS_GROUPS-1:0] dqs_mask_t;

endpackage

`default_nettype wire

/* src/read_fifo_group.sv */
// Resynchronization FIFO for one DQS group with its own sequencer reset
`default_nettype none

module read_fifo_group
	import read_datapath_pkg::*;
(
	input  logic      pll_afi_clk,
	input  logic      reset_n_afi_clk,
	read_fifo_if.fifo fifo
);

	// **************************************************
	// Sequencer reset
	// **************************************************

	// The sequencer level goes through one register before it reaches the
	// pointers, which keeps it off the pointer increment paths
	logic fifo_reset_q;

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			fifo_reset_q <= 1'b0;
		end
		else
		begin
			fifo_reset_q <= fifo.fifo_reset;
		end
	end

	// **************************************************
	// Pointers
	// **************************************************

	fifo_addr_t wr_ptr;
	fifo_addr_t rd_ptr;

	// Depth is a power of two so both pointers wrap on their own
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			wr_ptr <= '0;
		end
		else if (fifo_reset_q)
		begin
			wr_ptr <= '0;
		end
		else if (fifo.capture)
		begin
			wr_ptr <= wr_ptr + fifo_addr_t'(1);
		end
	end

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rd_ptr <= '0;
		end
		else if (fifo_reset_q)
		begin
			rd_ptr <= '0;
		end
		else if (fifo.read_enable)
		begin
			rd_ptr <= rd_ptr + fifo_addr_t'(1);
		end
	end

	// **************************************************
	// Storage
	// **************************************************

	// Flop storage, written at the capture edge
	group_data_t mem [READ_FIFO_DEPTH];

	always_ff @(posedge pll_afi_clk)
	begin
		if (fifo.capture)
		begin
			mem[wr_ptr] <= fifo.wr_data;
		end
	end

	// The head entry is visible without a read cycle, the pop only moves
	// the pointer on to the next word
	assign fifo.rd_data = mem[rd_ptr];

	// Empty and full are not tracked; the controller keeps the FIFO
	// between the two through its read scheduling

endmodule

`default_nettype wire

/* src/read_fifo_if.sv */
// Interface carrying one DQS group's capture, FIFO reset, read enable and read data
`default_nettype none

interface read_fifo_if
	import read_datapath_pkg::*;
();

	// Captured beats from the I/O for this group
	group_data_t wr_data;
	// Strobe that writes wr_data at the clock edge where it is high
	logic capture;
	// Sequencer level that clears both pointers
	logic fifo_reset;
	// Pops one word per cycle, from the latency control
	logic read_enable;
	// Head of the FIFO, shown combinationally
	group_data_t rd_data;

	// Capture side, driven from the top level pins
	modport phy (
		output wr_data,
		output capture,
		output fifo_reset
	);

	// Latency control drives the pop strobe
	modport ctrl (
		output read_enable
	);

	// The FIFO itself
	modport fifo (
		input  wr_data,
		input  capture,
		input  fifo_reset,
		input  read_enable,
		output rd_data
	);

	// Read data consumer, the AFI mapper
	modport sink (
		input  rd_data
	);

endinterface

`default_nettype wire

/* src/read_latency_ctrl.sv */
// Read latency control, delays the controller read enables by the sequencer latency count
`default_nettype none

module read_latency_ctrl
	import read_datapath_pkg::*;
(
	input  logic           pll_afi_clk,
	input  logic           reset_n_afi_clk,
	input  afi_phase_t     afi_rdata_en_i,
	input  afi_phase_t     afi_rdata_en_full_i,
	input  latency_t       seq_read_latency_count_i,
	read_fifo_if.ctrl      read_enable0_o,
	read_fifo_if.ctrl      read_enable1_o,
	output afi_phase_t     read_valid_o
);

	// **************************************************
	// Delay lines
	// **************************************************

	// Bit j holds the enable sampled j+1 edges ago, one line per AFI phase
	logic [AFI_RATE_RATIO-1:0][MAX_READ_LATENCY-1:0] valid_shifter;
	// The FIFO pops once per AFI cycle, so the full-rate enables collapse to one line
	logic [MAX_READ_LATENCY-1:0] full_shifter;

	// Tap chosen by the latency count
	latency_t tap_sel;
	// Registered pop strobe shared by both groups
	logic read_enable_q;

	// The output register adds one cycle on top of the delay line, so the
	// tap sits two below the latency count; counts below 2 are not legal
	assign tap_sel = seq_read_latency_count_i - latency_t'(2);

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			valid_shifter <= '0;
			full_shifter <= '0;
		end
		else
		begin
			for (int p = 0; p < AFI_RATE_RATIO; p++)
			begin
				valid_shifter[p] <= {valid_shifter[p][MAX_READ_LATENCY-2:0], afi_rdata_en_i[p]};
			end
			full_shifter <= {full_shifter[MAX_READ_LATENCY-2:0], |afi_rdata_en_full_i};
		end
	end

	// **************************************************
	// Tap selection
	// **************************************************

	// Both outputs are registered here so the FIFO pop and the mapper
	// valid line up with the head word of the FIFO
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			read_valid_o <= '0;
			read_enable_q <= 1'b0;
		end
		else
		begin
			for (int p = 0; p < AFI_RATE_RATIO; p++)
			begin
				read_valid_o[p] <= valid_shifter[p][tap_sel];
			end
			read_enable_q <= full_shifter[tap_sel];
		end
	end

	// Every group pops on the same cycle
	assign read_enable0_o.read_enable = read_enable_q;
	assign read_enable1_o.read_enable = read_enable_q;

endmodule

`default_nettype wire

/* test/tb_read_datapath.sv */
// Testbench for the half-rate read datapath that checks random captures and reads against a queue model
`default_nettype none

module tb_read_datapath
	import read_datapath_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	// Traffic blocks that each run with their own latency count
	localparam int NUM_BLOCKS = 12;
	localparam int BLOCK_CYCLES = 60;
	localparam int DRAIN_TIMEOUT = 40;
	// Ring of expected results that is longer than the largest read delay
	localparam int RING_SIZE = 32;
	// Enable history that is longer than the termination window
	localparam int HIST_SIZE = 16;

	// **************************************************
	// DUT connections
	// **************************************************

	logic                             pll_afi_clk;
	logic                             reset_n_afi_clk;
	group_data_t [NUM_DQS_GROUPS-1:0] ddio_phy_dq;
	dqs_mask_t                        ddio_capture;
	dqs_mask_t                        seq_read_fifo_reset;
	latency_t                         seq_read_latency_count;
	afi_phase_t                       afi_rdata_en;
	afi_phase_t                       afi_rdata_en_full;
	afi_data_t                        afi_rdata;
	afi_phase_t                       afi_rdata_valid;
	afi_data_t                        phy_mux_read_fifo_q;
	afi_phase_t                       force_oct_off;

	read_datapath DUT (
		.pll_afi_clk              (pll_afi_clk),
		.reset_n_afi_clk          (reset_n_afi_clk),
		.ddio_phy_dq_i            (ddio_phy_dq),
		.ddio_capture_i           (ddio_capture),
		.seq_read_fifo_reset_i    (seq_read_fifo_reset),
		.seq_read_latency_count_i (seq_read_latency_count),
		.afi_rdata_en_i           (afi_rdata_en),
		.afi_rdata_en_full_i      (afi_rdata_en_full),
		.afi_rdata_o              (afi_rdata),
		.afi_rdata_valid_o        (afi_rdata_valid),
		.phy_mux_read_fifo_q_o    (phy_mux_read_fifo_q),
		.force_oct_off_o          (force_oct_off)
	);

	// 4 ns clock period
	always #2 pll_afi_clk = ~pll_afi_clk;

	// **************************************************
	// Model state
	// **************************************************

	logic [31:0] lfsr_state;
	// Index of the last rising edge since reset was released
	int          cyc;
	latency_t    cur_latency;
	// Captured words not yet claimed by a read with one queue per group
	group_data_t q0[$];
	group_data_t q1[$];
	// Words held in each hardware FIFO whether claimed or not
	int          occ[NUM_DQS_GROUPS];
	// Reads due at a given edge are indexed by edge number modulo the ring size
	logic        due_flag[RING_SIZE];
	afi_phase_t  due_mask[RING_SIZE];
	group_data_t due_w0[RING_SIZE];
	group_data_t due_w1[RING_SIZE];
	int          pending_cnt;
	int          reads_checked;
	// OR of the full-rate enable phases sampled at each edge
	logic        en_hist[HIST_SIZE];

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken and the first bit ends up as the MSB
	function automatic logic [31:0] rand_bits(input int nbits);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < nbits; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	// Nibble k of the AFI bus holds beat k/2 of group k%2 so time slots are outermost
	function automatic afi_data_t remap_afi(input group_data_t w0, input group_data_t w1);
		afi_data_t   r;
		group_data_t src;
		for (int k = 0; k < NUM_TIMESLOTS * NUM_DQS_GROUPS; k++)
		begin
			src = (k % 2 == 0) ? w0 : w1;
			r[DQ_GROUP_WIDTH*k +: DQ_GROUP_WIDTH] = src[DQ_GROUP_WIDTH*(k/2) +: DQ_GROUP_WIDTH];
		end
		return r;
	endfunction

	// **************************************************
	// Compare tasks
	// **************************************************

	task automatic compare_afi_data(input string sig_name, input afi_data_t actual,
		input afi_data_t expected);
		if (actual !== expected)
		begin
			$display("FAILED %s got 0x%h expected 0x%h", sig_name, actual, expected);
			$display("Regression failed");
			$fatal(1, "Data mismatch on %s", sig_name);
		end
	endtask

	task automatic compare_valid(input string sig_name, input afi_phase_t actual,
		input afi_phase_t expected);
		if (actual !== expected)
		begin
			$display("FAILED %s got 0x%h expected 0x%h", sig_name, actual, expected);
			$display("Regression failed");
			$fatal(1, "Valid mismatch on %s", sig_name);
		end
	endtask

	task automatic compare_oct(input string sig_name, input afi_phase_t actual,
		input afi_phase_t expected);
		if (actual !== expected)
		begin
			$display("FAILED %s got 0x%h expected 0x%h", sig_name, actual, expected);
			$display("Regression failed");
			$fatal(1, "Termination mismatch on %s", sig_name);
		end
	endtask

	// **************************************************
	// Checking and driving
	// **************************************************

	// Checks the outputs after edge cyc against the model
	task automatic check_outputs();
		int   slot;
		logic window_busy;
		slot = cyc % RING_SIZE;
		window_busy = 1'b0;
		// Termination stays on while any enable sits in the window
		// Edges before reset count as idle
		for (int j = OCT_ON_DELAY; j <= OCT_OFF_DELAY; j++)
		begin
			if (cyc - j >= 1 && en_hist[(cyc - j) % HIST_SIZE])
			begin
				window_busy = 1'b1;
			end
		end
		compare_oct("force_oct_off_o", force_oct_off, window_busy ? 2'b00 : 2'b11);
		if (due_flag[slot])
		begin
			compare_valid("afi_rdata_valid_o", afi_rdata_valid, due_mask[slot]);
			compare_afi_data("afi_rdata_o", afi_rdata, remap_afi(due_w0[slot], due_w1[slot]));
			compare_afi_data("phy_mux_read_fifo_q_o", phy_mux_read_fifo_q,
				{due_w1[slot], due_w0[slot]});
			due_flag[slot] = 1'b0;
			pending_cnt--;
			reads_checked++;
			// The pop left both hardware FIFOs at this edge
			occ[0]--;
			occ[1]--;
		end
		else
		begin
			compare_valid("afi_rdata_valid_o", afi_rdata_valid, '0);
		end
	endtask

	// Waits for the next rising edge and samples 1 ns later where the registered outputs are settled
	task automatic step_cycle();
		@(posedge pll_afi_clk);
		#1;
		cyc++;
		check_outputs();
	endtask

	// Inputs for the coming edge cyc+1
	task automatic drive_inputs(input dqs_mask_t cap, input group_data_t w0,
		input group_data_t w1, input afi_phase_t en, input afi_phase_t en_full,
		input dqs_mask_t fifo_rst);
		ddio_capture = cap;
		ddio_phy_dq[0] = w0;
		ddio_phy_dq[1] = w1;
		afi_rdata_en = en;
		afi_rdata_en_full = en_full;
		seq_read_fifo_reset = fifo_rst;
		en_hist[(cyc + 1) % HIST_SIZE] = |en_full;
	endtask

	task automatic drive_idle();
		drive_inputs('0, '0, '0, '0, '0, '0);
	endtask

	task automatic idle_cycles(input int n);
		for (int i = 0; i < n; i++)
		begin
			drive_idle();
			step_cycle();
		end
	endtask

	// Random captures per group and a read when both groups have unclaimed words
	task automatic issue_traffic();
		dqs_mask_t   cap;
		group_data_t w0;
		group_data_t w1;
		afi_phase_t  en;
		afi_phase_t  en_full;
		int          slot;
		cap = '0;
		en = '0;
		en_full = '0;
		w0 = group_data_t'(rand_bits(GROUP_DATA_WIDTH));
		w1 = group_data_t'(rand_bits(GROUP_DATA_WIDTH));
		// One slot is kept free so a capture never lands on the word being read
		if (occ[0] < READ_FIFO_DEPTH - 1 && rand_bits(2) != 0)
		begin
			cap[0] = 1'b1;
			q0.push_back(w0);
			occ[0]++;
		end
		if (occ[1] < READ_FIFO_DEPTH - 1 && rand_bits(2) != 0)
		begin
			cap[1] = 1'b1;
			q1.push_back(w1);
			occ[1]++;
		end
		if (q0.size() > 0 && q1.size() > 0 && rand_bits(1) != 0)
		begin
			// Phase patterns are nonzero so every read pops and shows at least one valid bit
			en = afi_phase_t'(rand_bits(2) % 3 + 1);
			en_full = afi_phase_t'(rand_bits(2) % 3 + 1);
			// The enables are sampled at edge cyc+1 and the data appears after edge cyc+1+L
			slot = (cyc + 1 + int'(cur_latency)) % RING_SIZE;
			due_flag[slot] = 1'b1;
			due_mask[slot] = en;
			due_w0[slot] = q0.pop_front();
			due_w1[slot] = q1.pop_front();
			pending_cnt++;
		end
		drive_inputs(cap, w0, w1, en, en_full, '0);
	endtask

	// Runs idle cycles until every issued read has come back
	task automatic drain_reads();
		int waited;
		waited = 0;
		while (pending_cnt > 0)
		begin
			if (waited >= DRAIN_TIMEOUT)
			begin
				$display("Timed out waiting for %0d outstanding reads to return", pending_cnt);
				$display("Regression failed");
				$fatal(1, "Read drain timeout");
			end
			drive_idle();
			step_cycle();
			waited++;
		end
	endtask

	// One-cycle sequencer reset of a single group whose pointers clear two edges after the drive
	task automatic pulse_fifo_reset(input int g);
		dqs_mask_t rst;
		rst = '0;
		rst[g] = 1'b1;
		drive_inputs('0, '0, '0, '0, '0, rst);
		step_cycle();
		drive_idle();
		step_cycle();
		drive_idle();
		step_cycle();
		if (g == 0)
		begin
			q0.delete();
		end
		else
		begin
			q1.delete();
		end
		occ[g] = 0;
	endtask

	// **************************************************
	// Main sequence
	// **************************************************

	initial
	begin
		pll_afi_clk = 1'b0;
		reset_n_afi_clk = 1'b0;
		lfsr_state = 32'h4c14_9b2a;
		cyc = 0;
		pending_cnt = 0;
		reads_checked = 0;
		cur_latency = latency_t'(2);
		occ[0] = 0;
		occ[1] = 0;
		for (int i = 0; i < RING_SIZE; i++)
		begin
			due_flag[i] = 1'b0;
		end
		for (int i = 0; i < HIST_SIZE; i++)
		begin
			en_hist[i] = 1'b0;
		end
		ddio_phy_dq = '0;
		ddio_capture = '0;
		seq_read_fifo_reset = '0;
		seq_read_latency_count = cur_latency;
		afi_rdata_en = '0;
		afi_rdata_en_full = '0;

		// Both registered outputs must read zero throughout reset
		repeat (16)
		begin
			@(posedge pll_afi_clk);
			#1;
			compare_valid("afi_rdata_valid_o", afi_rdata_valid, '0);
			compare_oct("force_oct_off_o", force_oct_off, '0);
		end
		reset_n_afi_clk = 1'b1;

		for (int blk = 0; blk < NUM_BLOCKS; blk++)
		begin
			// Latency changes only with the delay lines empty
			cur_latency = latency_t'(2 + rand_bits(4) % 14);
			seq_read_latency_count = cur_latency;
			for (int i = 0; i < BLOCK_CYCLES; i++)
			begin
				issue_traffic();
				step_cycle();
			end
			drain_reads();
			// Flush the delay lines and let the termination window run out
			idle_cycles(MAX_READ_LATENCY + 1);
			if (rand_bits(1) != 0)
			begin
				pulse_fifo_reset(int'(rand_bits(1)));
			end
		end

		if (reads_checked >= NUM_BLOCKS)
		begin
			$display("Regression passed");
			$finish;
		end
		else
		begin
			$display("Only %0d reads were checked, too few to exercise the datapath",
				reads_checked);
			$display("Regression failed");
			$fatal(1, "Too few reads");
		end
	end

endmodule

`default_nettype wire
